/* common/wb_pkg.sv */
// Shared constants for the Wishbone subsystem
// Bus widths, the address map, target indices and register word offsets
// RTL and testbench refer to these through wb_pkg:: scoped names
package wb_pkg;

	localparam int WB_ADDR_W = 32;
	localparam int WB_DATA_W = 32;
	// One select bit per byte lane
	localparam int WB_SEL_W = WB_DATA_W / 8;

	// Address windows, limits are inclusive
	localparam logic [WB_ADDR_W-1:0] SRAM_BASE = 32'h0000_0000;
	localparam logic [WB_ADDR_W-1:0] SRAM_LIMIT = 32'h0000_03FF;
	localparam logic [WB_ADDR_W-1:0] REGS_BASE = 32'h0000_1000;
	localparam logic [WB_ADDR_W-1:0] REGS_LIMIT = 32'h0000_100F;
	localparam logic [WB_ADDR_W-1:0] TMR_BASE = 32'h0000_2000;
	localparam logic [WB_ADDR_W-1:0] TMR_LIMIT = 32'h0000_200F;

	// Target indices in the interconnect
	localparam int TGT_ID_W = 3;
	localparam logic [TGT_ID_W-1:0] TGT_SRAM = 3'd0;
	localparam logic [TGT_ID_W-1:0] TGT_REGS = 3'd1;
	localparam logic [TGT_ID_W-1:0] TGT_TMR = 3'd2;
	localparam logic [TGT_ID_W-1:0] TGT_ERR = 3'd3;
	// No cycle in progress
	localparam logic [TGT_ID_W-1:0] TGT_NONE = 3'b111;

	// Register block word offsets
	localparam logic [1:0] REG_ID = 2'd0;
	localparam logic [1:0] REG_SCRATCH = 2'd1;
	localparam logic [1:0] REG_GPIO_OUT = 2'd2;
	localparam logic [1:0] REG_GPIO_IN = 2'd3;

	// Timer word offsets
	localparam logic [1:0] TMR_CTRL = 2'd0;
	localparam logic [1:0] TMR_COUNT = 2'd1;
	localparam logic [1:0] TMR_CMP = 2'd2;
	localparam logic [1:0] TMR_STATUS = 2'd3;

	localparam logic [WB_DATA_W-1:0] REGS_ID_VALUE = 32'h5742_0103;

	// Replace the bytes of old_w enabled in sel with those of new_w
	function automatic logic [WB_DATA_W-1:0] merge_bytes(
		input logic [WB_DATA_W-1:0] old_w,
		input logic [WB_DATA_W-1:0] new_w,
		input logic [WB_SEL_W-1:0] sel
	);
		logic [WB_DATA_W-1:0] res;
		res = old_w;
		for (int b = 0; b < WB_SEL_W; b++) begin
			if (sel[b]) begin
				res[8*b +: 8] = new_w[8*b +: 8];
			end
		end
		return res;
	endfunction

endpackage

/* wb_interconnect/wb_arbiter.sv */
`timescale 1ns/10ps
// Round-robin grant holder, one per interconnect target
// Grant is registered a cycle after a request and held while it stays up
module wb_arbiter #(
	parameter int N_REQ = 1,
	localparam int ID_W = (N_REQ > 1) ? $clog2(N_REQ) : 1
) (
	input  logic             clk,
	input  logic             rstn,
	input  logic [N_REQ-1:0] req_i,
	output logic             gnt_o,
	output logic [ID_W-1:0]  gnt_id_o
);

	logic [N_REQ-1:0] gnt_vec;
	logic [N_REQ-1:0] last_gnt;
	logic [N_REQ-1:0] above;
	logic [N_REQ-1:0] cand;
	logic [N_REQ-1:0] pick;
	logic [ID_W-1:0]  pick_id;
	logic [ID_W-1:0]  gnt_id_r;

	// Requesters strictly above the last winner
	always_comb begin
		above = '0;
		for (int i = 1; i < N_REQ; i++) begin
			above[i] = above[i-1] | last_gnt[i-1];
		end
	end

	// Prefer the masked set, else wrap to the lowest request
	assign cand = (|(req_i & above)) ? (req_i & above) : req_i;
	// Lowest set bit wins
	assign pick = cand & (~cand + 1'b1);

	always_comb begin
		pick_id = '0;
		for (int i = 0; i < N_REQ; i++) begin
			if (pick[i]) begin
				pick_id = ID_W'(i);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			gnt_vec <= '0;
			last_gnt <= '0;
			gnt_id_r <= '0;
		end else if (|gnt_vec) begin
			// Hold until the owner lets go
			if (!(|(gnt_vec & req_i))) begin
				gnt_vec <= '0;
			end
		end else if (|req_i) begin
			gnt_vec <= pick;
			last_gnt <= pick;
			gnt_id_r <= pick_id;
		end
	end

	assign gnt_o = |gnt_vec;
	assign gnt_id_o = gnt_id_r;

	a_gnt_onehot: assert property (@(posedge clk) disable iff (!rstn) $onehot0(gnt_vec));

endmodule

/* wb_interconnect/wb_interconnect.sv */
`timescale 1ns/10ps
// Address-decoding interconnect between one Wishbone master and three targets
// The target is latched when a cycle starts, then its arbiter grants it
// and the master is routed through; responses come back from that target
// Addresses outside every window hit an internal ERR responder
module wb_interconnect #(
	parameter int ADDR_W = 32,
	parameter int DATA_W = 32,
	parameter logic [ADDR_W-1:0] T0_BASE = '0,
	parameter logic [ADDR_W-1:0] T0_LIMIT = '0,
	parameter logic [ADDR_W-1:0] T1_BASE = '0,
	parameter logic [ADDR_W-1:0] T1_LIMIT = '0,
	parameter logic [ADDR_W-1:0] T2_BASE = '0,
	parameter logic [ADDR_W-1:0] T2_LIMIT = '0
) (
	input  logic                clk,
	input  logic                rstn,
	// Master port
	input  logic                m_cyc_i,
	input  logic                m_stb_i,
	input  logic                m_we_i,
	input  logic [ADDR_W-1:0]   m_adr_i,
	input  logic [DATA_W/8-1:0] m_sel_i,
	input  logic [DATA_W-1:0]   m_dat_i,
	output logic [DATA_W-1:0]   m_dat_o,
	output logic                m_ack_o,
	output logic                m_err_o,
	// Target 0
	output logic                t0_cyc_o,
	output logic                t0_stb_o,
	output logic                t0_we_o,
	output logic [ADDR_W-1:0]   t0_adr_o,
	output logic [DATA_W/8-1:0] t0_sel_o,
	output logic [DATA_W-1:0]   t0_dat_o,
	input  logic [DATA_W-1:0]   t0_dat_i,
	input  logic                t0_ack_i,
	input  logic                t0_err_i,
	// Target 1
	output logic                t1_cyc_o,
	output logic                t1_stb_o,
	output logic                t1_we_o,
	output logic [ADDR_W-1:0]   t1_adr_o,
	output logic [DATA_W/8-1:0] t1_sel_o,
	output logic [DATA_W-1:0]   t1_dat_o,
	input  logic [DATA_W-1:0]   t1_dat_i,
	input  logic                t1_ack_i,
	input  logic                t1_err_i,
	// Target 2
	output logic                t2_cyc_o,
	output logic                t2_stb_o,
	output logic                t2_we_o,
	output logic [ADDR_W-1:0]   t2_adr_o,
	output logic [DATA_W/8-1:0] t2_sel_o,
	output logic [DATA_W-1:0]   t2_dat_o,
	input  logic [DATA_W-1:0]   t2_dat_i,
	input  logic                t2_ack_i,
	input  logic                t2_err_i
);

	// Three real targets plus the decode-fail one
	localparam int NT = 4;

	logic [wb_pkg::TGT_ID_W-1:0] sel;
	logic [NT-1:0] req;
	logic [NT-1:0] gnt;
	logic [0:0]    gnt_id [NT];
	logic [NT-1:0] route;
	logic          err_r;

	function automatic logic [wb_pkg::TGT_ID_W-1:0] decode(input logic [ADDR_W-1:0] adr);
		if (adr >= T0_BASE && adr <= T0_LIMIT) begin
			return wb_pkg::TGT_SRAM;
		end
		if (adr >= T1_BASE && adr <= T1_LIMIT) begin
			return wb_pkg::TGT_REGS;
		end
		if (adr >= T2_BASE && adr <= T2_LIMIT) begin
			return wb_pkg::TGT_TMR;
		end
		return wb_pkg::TGT_ERR;
	endfunction

	// Latch the target on cycle start and release it on the edge after ACK or ERR
	always_ff @(posedge clk) begin
		if (!rstn) begin
			sel <= wb_pkg::TGT_NONE;
		end else if (sel == wb_pkg::TGT_NONE) begin
			if (m_cyc_i && m_stb_i) begin
				sel <= decode(m_adr_i);
			end
		end else if (m_ack_o || m_err_o || !m_cyc_i) begin
			// Abandoned cycles free the target too
			sel <= wb_pkg::TGT_NONE;
		end
	end

	for (genvar k = 0; k < NT; k++) begin : g_arb
		localparam logic [wb_pkg::TGT_ID_W-1:0] IDX = k;
		assign req[k] = (sel == IDX);
		wb_arbiter #(
			.N_REQ(1)
		) i_arb (
			.clk(clk),
			.rstn(rstn),
			.req_i(req[k:k]),
			.gnt_o(gnt[k]),
			.gnt_id_o(gnt_id[k])
		);
		// Master 0 owns the path once its grant is in
		assign route[k] = req[k] & gnt[k] & (gnt_id[k] == 1'b0);
	end

	// Idle targets see zeros on every master signal
	assign t0_cyc_o = route[0] & m_cyc_i;
	assign t0_stb_o = route[0] & m_stb_i;
	assign t0_we_o = route[0] & m_we_i;
	assign t0_adr_o = route[0] ? m_adr_i : '0;
	assign t0_sel_o = route[0] ? m_sel_i : '0;
	assign t0_dat_o = route[0] ? m_dat_i : '0;

	assign t1_cyc_o = route[1] & m_cyc_i;
	assign t1_stb_o = route[1] & m_stb_i;
	assign t1_we_o = route[1] & m_we_i;
	assign t1_adr_o = route[1] ? m_adr_i : '0;
	assign t1_sel_o = route[1] ? m_sel_i : '0;
	assign t1_dat_o = route[1] ? m_dat_i : '0;

	assign t2_cyc_o = route[2] & m_cyc_i;
	assign t2_stb_o = route[2] & m_stb_i;
	assign t2_we_o = route[2] & m_we_i;
	assign t2_adr_o = route[2] ? m_adr_i : '0;
	assign t2_sel_o = route[2] ? m_sel_i : '0;
	assign t2_dat_o = route[2] ? m_dat_i : '0;

	// Decode-fail responder raises ERR one cycle after STB
	always_ff @(posedge clk) begin
		if (!rstn) begin
			err_r <= 1'b0;
		end else begin
			err_r <= route[3] & m_cyc_i & m_stb_i & ~err_r;
		end
	end

	// Responses stay zero unless the selected target is granted
	always_comb begin
		m_dat_o = '0;
		m_ack_o = 1'b0;
		m_err_o = 1'b0;
		case (sel)
			wb_pkg::TGT_SRAM: begin
				if (route[0]) begin
					m_dat_o = t0_dat_i;
					m_ack_o = t0_ack_i;
					m_err_o = t0_err_i;
				end
			end
			wb_pkg::TGT_REGS: begin
				if (route[1]) begin
					m_dat_o = t1_dat_i;
					m_ack_o = t1_ack_i;
					m_err_o = t1_err_i;
				end
			end
			wb_pkg::TGT_TMR: begin
				if (route[2]) begin
					m_dat_o = t2_dat_i;
					m_ack_o = t2_ack_i;
					m_err_o = t2_err_i;
				end
			end
			wb_pkg::TGT_ERR: begin
				m_err_o = route[3] & err_r;
			end
			default: begin
				m_ack_o = 1'b0;
			end
		endcase
	end

	a_ack_err_excl: assert property (@(posedge clk) disable iff (!rstn)
		!(m_ack_o && m_err_o));

	// A live strobe keeps pointing at the target its held address decodes to
	a_sel_hold: assert property (@(posedge clk) disable iff (!rstn)
		(sel != wb_pkg::TGT_NONE && m_cyc_i && m_stb_i) |-> (sel == decode(m_adr_i)));

endmodule

/* logic/wb_sram.sv */
`timescale 1ns/10ps
// Word-addressed SRAM behind a Wishbone classic target port
// Byte lanes written per SEL, ACK registered one cycle after STB
module wb_sram #(
	parameter int ADDR_W = 32,
	parameter int DATA_W = 32,
	parameter int SRAM_WORDS = 256
) (
	input  logic                clk,
	input  logic                rstn,
	input  logic                cyc_i,
	input  logic                stb_i,
	input  logic                we_i,
	input  logic [ADDR_W-1:0]   adr_i,
	input  logic [DATA_W/8-1:0] sel_i,
	input  logic [DATA_W-1:0]   dat_i,
	output logic [DATA_W-1:0]   dat_o,
	output logic                ack_o,
	output logic                err_o
);

	localparam int IDX_W = $clog2(SRAM_WORDS);

	logic [DATA_W-1:0] mem [SRAM_WORDS];
	logic [IDX_W-1:0]  idx;
	logic [DATA_W-1:0] rdat_r;
	logic              ack_r;
	logic              access;

	// Word index within the window
	assign idx = adr_i[IDX_W+1:2];
	// New access only while no ACK is out
	assign access = cyc_i & stb_i & ~ack_r;

	always_ff @(posedge clk) begin
		if (access && we_i) begin
			mem[idx] <= wb_pkg::merge_bytes(mem[idx], dat_i, sel_i);
		end
		if (access) begin
			rdat_r <= mem[idx];
		end
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			ack_r <= 1'b0;
		end else begin
			ack_r <= access;
		end
	end

	assign dat_o = rdat_r;
	assign ack_o = ack_r;
	// Every SRAM address is valid
	assign err_o = 1'b0;

	a_ack_after_stb: assert property (@(posedge clk) disable iff (!rstn)
		ack_o |-> $past(cyc_i && stb_i));

endmodule

/* logic/wb_gpio_regs.sv */
`timescale 1ns/10ps
// Register block target: ID, scratch, GPIO output and GPIO input words
// Writes to the read-only words answer ERR and leave state unchanged
module wb_gpio_regs #(
	parameter int ADDR_W = 32,
	parameter int DATA_W = 32
) (
	input  logic                clk,
	input  logic                rstn,
	input  logic                cyc_i,
	input  logic                stb_i,
	input  logic                we_i,
	input  logic [ADDR_W-1:0]   adr_i,
	input  logic [DATA_W/8-1:0] sel_i,
	input  logic [DATA_W-1:0]   dat_i,
	output logic [DATA_W-1:0]   dat_o,
	output logic                ack_o,
	output logic                err_o,
	input  logic [DATA_W-1:0]   gpio_i,
	output logic [DATA_W-1:0]   gpio_o
);

	logic [1:0]        ofs;
	logic              access;
	logic              wr_ro;
	logic [DATA_W-1:0] scratch;
	logic [DATA_W-1:0] gpio_out;
	logic [DATA_W-1:0] gpio_in_r;
	logic [DATA_W-1:0] rd_word;
	logic [DATA_W-1:0] wval;
	logic [DATA_W-1:0] rdat_r;
	logic              ack_r;
	logic              err_r;

	assign ofs = adr_i[3:2];
	assign access = cyc_i & stb_i & ~ack_r & ~err_r;
	// ID and GPIO input reject writes
	assign wr_ro = we_i & (ofs == wb_pkg::REG_ID || ofs == wb_pkg::REG_GPIO_IN);

	always_comb begin
		case (ofs)
			wb_pkg::REG_ID:       rd_word = wb_pkg::REGS_ID_VALUE;
			wb_pkg::REG_SCRATCH:  rd_word = scratch;
			wb_pkg::REG_GPIO_OUT: rd_word = gpio_out;
			default:              rd_word = gpio_in_r;
		endcase
	end

	// Current word with the enabled write bytes laid over it
	assign wval = wb_pkg::merge_bytes(rd_word, dat_i, sel_i);

	// Pin sampling and storage
	always_ff @(posedge clk) begin
		gpio_in_r <= gpio_i;
		if (access && we_i && ofs == wb_pkg::REG_SCRATCH) begin
			scratch <= wval;
		end
		if (access) begin
			rdat_r <= rd_word;
		end
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			gpio_out <= '0;
			ack_r <= 1'b0;
			err_r <= 1'b0;
		end else begin
			ack_r <= access & ~wr_ro;
			err_r <= access & wr_ro;
			if (access && we_i && ofs == wb_pkg::REG_GPIO_OUT) begin
				gpio_out <= wval;
			end
		end
	end

	assign dat_o = rdat_r;
	assign ack_o = ack_r;
	assign err_o = err_r;
	assign gpio_o = gpio_out;

endmodule

/* logic/wb_timer.sv */
`timescale 1ns/10ps
// Free-running timer target with compare match and interrupt
// CTRL bit 0 runs the counter, bit 1 enables irq_o
// STATUS bit 0 is sticky on match and is cleared by writing a 1
module wb_timer #(
	parameter int ADDR_W = 32,
	parameter int DATA_W = 32
) (
	input  logic                clk,
	input  logic                rstn,
	input  logic                cyc_i,
	input  logic                stb_i,
	input  logic                we_i,
	input  logic [ADDR_W-1:0]   adr_i,
	input  logic [DATA_W/8-1:0] sel_i,
	input  logic [DATA_W-1:0]   dat_i,
	output logic [DATA_W-1:0]   dat_o,
	output logic                ack_o,
	output logic                err_o,
	output logic                irq_o
);

	logic [1:0]        ofs;
	logic              access;
	logic              wr;
	logic [1:0]        ctrl;
	logic [DATA_W-1:0] count;
	logic [DATA_W-1:0] cmp;
	logic              status;
	logic [DATA_W-1:0] rd_word;
	logic [DATA_W-1:0] wval;
	logic [DATA_W-1:0] rdat_r;
	logic              ack_r;

	assign ofs = adr_i[3:2];
	assign access = cyc_i & stb_i & ~ack_r;
	assign wr = access & we_i;

	always_comb begin
		case (ofs)
			wb_pkg::TMR_CTRL:  rd_word = DATA_W'(ctrl);
			wb_pkg::TMR_COUNT: rd_word = count;
			wb_pkg::TMR_CMP:   rd_word = cmp;
			default:           rd_word = DATA_W'(status);
		endcase
	end

	assign wval = wb_pkg::merge_bytes(rd_word, dat_i, sel_i);

	always_ff @(posedge clk) begin
		if (!rstn) begin
			ctrl <= '0;
			count <= '0;
			cmp <= '1;
			status <= 1'b0;
			ack_r <= 1'b0;
		end else begin
			ack_r <= access;
			if (wr && ofs == wb_pkg::TMR_CTRL) begin
				ctrl <= wval[1:0];
			end
			if (wr && ofs == wb_pkg::TMR_CMP) begin
				cmp <= wval;
			end
			// Bus load beats the increment
			if (wr && ofs == wb_pkg::TMR_COUNT) begin
				count <= wval;
			end else if (ctrl[0]) begin
				count <= count + 1'b1;
			end
			// Only a 1 written through byte lane 0 clears, a match sets it
			if (wr && ofs == wb_pkg::TMR_STATUS && sel_i[0] && wval[0]) begin
				status <= 1'b0;
			end else if (count == cmp) begin
				status <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (access) begin
			rdat_r <= rd_word;
		end
	end

	assign dat_o = rdat_r;
	assign ack_o = ack_r;
	assign err_o = 1'b0;
	assign irq_o = status & ctrl[1];

endmodule

/* logic/wb_subsys_top.sv */
`timescale 1ns/10ps
// Wishbone subsystem top: one external master port, three peripherals
// SRAM, register block and timer sit behind the address-decoding interconnect
module wb_subsys_top #(
	parameter int ADDR_W = wb_pkg::WB_ADDR_W,
	parameter int DATA_W = wb_pkg::WB_DATA_W,
	parameter int SRAM_WORDS = 256
) (
	input  logic                clk,
	input  logic                rstn,
	input  logic                m_cyc_i,
	input  logic                m_stb_i,
	input  logic                m_we_i,
	input  logic [ADDR_W-1:0]   m_adr_i,
	input  logic [DATA_W/8-1:0] m_sel_i,
	input  logic [DATA_W-1:0]   m_dat_i,
	output logic [DATA_W-1:0]   m_dat_o,
	output logic                m_ack_o,
	output logic                m_err_o,
	input  logic [31:0]         gpio_i,
	output logic [31:0]         gpio_o,
	output logic                irq_o
);

	// SRAM target
	logic                sram_cyc, sram_stb, sram_we, sram_ack, sram_err;
	logic [ADDR_W-1:0]   sram_adr;
	logic [DATA_W/8-1:0] sram_sel;
	logic [DATA_W-1:0]   sram_wdat, sram_rdat;
	// Register block target
	logic                regs_cyc, regs_stb, regs_we, regs_ack, regs_err;
	logic [ADDR_W-1:0]   regs_adr;
	logic [DATA_W/8-1:0] regs_sel;
	logic [DATA_W-1:0]   regs_wdat, regs_rdat;
	// Timer target
	logic                tmr_cyc, tmr_stb, tmr_we, tmr_ack, tmr_err;
	logic [ADDR_W-1:0]   tmr_adr;
	logic [DATA_W/8-1:0] tmr_sel;
	logic [DATA_W-1:0]   tmr_wdat, tmr_rdat;

	wb_interconnect #(
		.ADDR_W(ADDR_W),
		.DATA_W(DATA_W),
		.T0_BASE(wb_pkg::SRAM_BASE),
		.T0_LIMIT(wb_pkg::SRAM_LIMIT),
		.T1_BASE(wb_pkg::REGS_BASE),
		.T1_LIMIT(wb_pkg::REGS_LIMIT),
		.T2_BASE(wb_pkg::TMR_BASE),
		.T2_LIMIT(wb_pkg::TMR_LIMIT)
	) i_ic (
		.clk(clk),
		.rstn(rstn),
		.m_cyc_i(m_cyc_i),
		.m_stb_i(m_stb_i),
		.m_we_i(m_we_i),
		.m_adr_i(m_adr_i),
		.m_sel_i(m_sel_i),
		.m_dat_i(m_dat_i),
		.m_dat_o(m_dat_o),
		.m_ack_o(m_ack_o),
		.m_err_o(m_err_o),
		.t0_cyc_o(sram_cyc),
		.t0_stb_o(sram_stb),
		.t0_we_o(sram_we),
		.t0_adr_o(sram_adr),
		.t0_sel_o(sram_sel),
		.t0_dat_o(sram_wdat),
		.t0_dat_i(sram_rdat),
		.t0_ack_i(sram_ack),
		.t0_err_i(sram_err),
		.t1_cyc_o(regs_cyc),
		.t1_stb_o(regs_stb),
		.t1_we_o(regs_we),
		.t1_adr_o(regs_adr),
		.t1_sel_o(regs_sel),
		.t1_dat_o(regs_wdat),
		.t1_dat_i(regs_rdat),
		.t1_ack_i(regs_ack),
		.t1_err_i(regs_err),
		.t2_cyc_o(tmr_cyc),
		.t2_stb_o(tmr_stb),
		.t2_we_o(tmr_we),
		.t2_adr_o(tmr_adr),
		.t2_sel_o(tmr_sel),
		.t2_dat_o(tmr_wdat),
		.t2_dat_i(tmr_rdat),
		.t2_ack_i(tmr_ack),
		.t2_err_i(tmr_err)
	);

	wb_sram #(
		.ADDR_W(ADDR_W),
		.DATA_W(DATA_W),
		.SRAM_WORDS(SRAM_WORDS)
	) i_sram (
		.clk(clk),
		.rstn(rstn),
		.cyc_i(sram_cyc),
		.stb_i(sram_stb),
		.we_i(sram_we),
		.adr_i(sram_adr),
		.sel_i(sram_sel),
		.dat_i(sram_wdat),
		.dat_o(sram_rdat),
		.ack_o(sram_ack),
		.err_o(sram_err)
	);

	wb_gpio_regs #(
		.ADDR_W(ADDR_W),
		.DATA_W(DATA_W)
	) i_regs (
		.clk(clk),
		.rstn(rstn),
		.cyc_i(regs_cyc),
		.stb_i(regs_stb),
		.we_i(regs_we),
		.adr_i(regs_adr),
		.sel_i(regs_sel),
		.dat_i(regs_wdat),
		.dat_o(regs_rdat),
		.ack_o(regs_ack),
		.err_o(regs_err),
		.gpio_i(gpio_i),
		.gpio_o(gpio_o)
	);

	wb_timer #(
		.ADDR_W(ADDR_W),
		.DATA_W(DATA_W)
	) i_tmr (
		.clk(clk),
		.rstn(rstn),
		.cyc_i(tmr_cyc),
		.stb_i(tmr_stb),
		.we_i(tmr_we),
		.adr_i(tmr_adr),
		.sel_i(tmr_sel),
		.dat_i(tmr_wdat),
		.dat_o(tmr_rdat),
		.ack_o(tmr_ack),
		.err_o(tmr_err),
		.irq_o(irq_o)
	);

endmodule

/* verif/wb_ref_model.svh */
// Reference model for the subsystem testbench, included inside the testbench module
// Mirrors SRAM words, the scratch and GPIO output registers, and the address decode
// Bytes never written are tracked so reads compare only known lanes
`ifndef WB_REF_MODEL_SVH
`define WB_REF_MODEL_SVH

localparam int MODEL_WORDS = (wb_pkg::SRAM_LIMIT - wb_pkg::SRAM_BASE + 1) / 4;

logic [31:0] sram_word [MODEL_WORDS];
logic [3:0]  sram_known [MODEL_WORDS];
logic [31:0] scratch_word;
logic [3:0]  scratch_known;
logic [31:0] gpio_out_word;

// Byte enables spread to a bit mask
function automatic logic [31:0] lane_mask(input logic [3:0] sel);
	return {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
endfunction

function automatic logic [31:0] merge_write(input logic [31:0] old_w, input logic [31:0] new_w,
	input logic [3:0] sel);
	logic [31:0] m;
	m = lane_mask(sel);
	return (old_w & ~m) | (new_w & m);
endfunction

function automatic logic [wb_pkg::TGT_ID_W-1:0] decode_addr(input logic [31:0] adr);
	if (adr >= wb_pkg::SRAM_BASE && adr <= wb_pkg::SRAM_LIMIT) begin
		return wb_pkg::TGT_SRAM;
	end
	if (adr >= wb_pkg::REGS_BASE && adr <= wb_pkg::REGS_LIMIT) begin
		return wb_pkg::TGT_REGS;
	end
	if (adr >= wb_pkg::TMR_BASE && adr <= wb_pkg::TMR_LIMIT) begin
		return wb_pkg::TGT_TMR;
	end
	return wb_pkg::TGT_ERR;
endfunction

// ERR for unmapped addresses and for writes to read-only registers
function automatic logic expect_err(input logic [31:0] adr, input logic we);
	logic [1:0] ofs;
	ofs = adr[3:2];
	case (decode_addr(adr))
		wb_pkg::TGT_ERR: return 1'b1;
		wb_pkg::TGT_REGS: return we && (ofs == wb_pkg::REG_ID || ofs == wb_pkg::REG_GPIO_IN);
		default: return 1'b0;
	endcase
endfunction

function automatic int sram_index(input logic [31:0] adr);
	return (adr - wb_pkg::SRAM_BASE) >> 2;
endfunction

task automatic model_reset();
	int i;
	for (i = 0; i < MODEL_WORDS; i++) begin
		sram_known[i] = 4'h0;
	end
	scratch_known = 4'h0;
	gpio_out_word = 32'h0;
endtask

task automatic model_write(input logic [31:0] adr, input logic [31:0] dat, input logic [3:0] sel);
	int idx;
	if (decode_addr(adr) == wb_pkg::TGT_SRAM) begin
		idx = sram_index(adr);
		sram_word[idx] = merge_write(sram_word[idx], dat, sel);
		sram_known[idx] = sram_known[idx] | sel;
	end else if (decode_addr(adr) == wb_pkg::TGT_REGS) begin
		if (adr[3:2] == wb_pkg::REG_SCRATCH) begin
			scratch_word = merge_write(scratch_word, dat, sel);
			scratch_known = scratch_known | sel;
		end else if (adr[3:2] == wb_pkg::REG_GPIO_OUT) begin
			gpio_out_word = merge_write(gpio_out_word, dat, sel);
		end
	end
endtask

// Expected read word and the lanes that are known
task automatic model_read(input logic [31:0] adr, input logic [31:0] pins,
	output logic [31:0] exp, output logic [31:0] mask);
	int idx;
	exp = 32'h0;
	mask = '1;
	case (decode_addr(adr))
		wb_pkg::TGT_SRAM: begin
			idx = sram_index(adr);
			exp = sram_word[idx];
			mask = lane_mask(sram_known[idx]);
		end
		wb_pkg::TGT_REGS: begin
			case (adr[3:2])
				wb_pkg::REG_ID: exp = wb_pkg::REGS_ID_VALUE;
				wb_pkg::REG_SCRATCH: begin
					exp = scratch_word;
					mask = lane_mask(scratch_known);
				end
				wb_pkg::REG_GPIO_OUT: exp = gpio_out_word;
				default: exp = pins;
			endcase
		end
		// Timer words are checked by the timer test itself
		wb_pkg::TGT_TMR: mask = 32'h0;
		default: exp = 32'h0;
	endcase
endtask

`endif

/* verif/tb_wb_subsys.sv */
`timescale 1ns/10ps
// Testbench for the Wishbone subsystem top
// Drives the master port on the falling edge and checks against the included model
// Random addresses, data and selects come from an LCG with a fixed seed
module tb_wb_subsys;

	localparam int CLK_PERIOD = 40;
	localparam int XFER_LIMIT = 20;
	localparam int N_SRAM = 200;
	localparam int N_DEC = 20;
	localparam int N_MIX = 200;
	// Register, read-only and timer transfers, rounded up
	localparam int N_DIRECTED = 60;
	localparam int N_XFER = 2 * N_SRAM + N_DEC + 2 + N_MIX + N_DIRECTED;
	// Reset and the timer wait come on top
	localparam int MARGIN_CYCLES = 500;

	logic        clk;
	logic        rstn;
	logic        m_cyc_i;
	logic        m_stb_i;
	logic        m_we_i;
	logic [31:0] m_adr_i;
	logic [3:0]  m_sel_i;
	logic [31:0] m_dat_i;
	logic [31:0] m_dat_o;
	logic        m_ack_o;
	logic        m_err_o;
	logic [31:0] gpio_i;
	logic [31:0] gpio_o;
	logic        irq_o;

	int unsigned lcg_state;
	int errors;
	int checks;
	int test_errs;
	int tests_run;
	int tests_failed;
	int resp_count;

	`include "wb_ref_model.svh"

	wb_subsys_top i_dut (
		.clk(clk),
		.rstn(rstn),
		.m_cyc_i(m_cyc_i),
		.m_stb_i(m_stb_i),
		.m_we_i(m_we_i),
		.m_adr_i(m_adr_i),
		.m_sel_i(m_sel_i),
		.m_dat_i(m_dat_i),
		.m_dat_o(m_dat_o),
		.m_ack_o(m_ack_o),
		.m_err_o(m_err_o),
		.gpio_i(gpio_i),
		.gpio_o(gpio_o),
		.irq_o(irq_o)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// Response cycles seen by the master, sampled where they are stable
	always @(negedge clk) begin
		if (rstn && (m_ack_o || m_err_o)) begin
			resp_count++;
		end
		if (m_ack_o && m_err_o) begin
			$display("ACK and ERR were high together at %0t", $time);
			errors++;
			test_errs++;
		end
	end

	initial begin
		#(CLK_PERIOD * (N_XFER * XFER_LIMIT + MARGIN_CYCLES));
		$display("Watchdog expired, the tests did not finish in time");
		$display("Verification failed");
		$finish;
	end

	// Two LCG steps, upper halves only
	function automatic logic [31:0] lcg_next();
		logic [15:0] hi;
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		hi = lcg_state[31:16];
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return {hi, lcg_state[31:16]};
	endfunction

	function automatic logic [3:0] rand_sel();
		logic [31:0] r;
		r = lcg_next();
		// An empty select would make the write a no-op
		return (r[3:0] == 4'h0) ? 4'hF : r[3:0];
	endfunction

	function automatic logic [31:0] reg_addr(input logic [1:0] ofs);
		return wb_pkg::REGS_BASE + {28'h0, ofs, 2'b00};
	endfunction

	function automatic logic [31:0] tmr_addr(input logic [1:0] ofs);
		return wb_pkg::TMR_BASE + {28'h0, ofs, 2'b00};
	endfunction

	function automatic logic [31:0] sram_addr();
		logic [31:0] r;
		r = lcg_next();
		return wb_pkg::SRAM_BASE + {22'h0, r[9:2], 2'b00};
	endfunction

	// Word address outside every window
	function automatic logic [31:0] outside_addr();
		logic [31:0] a;
		a = lcg_next() & ~32'h3;
		if (decode_addr(a) != wb_pkg::TGT_ERR) begin
			a = a | 32'h0001_0000;
		end
		return a;
	endfunction

	task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			$display("ERROR at %0t: %s, got %h, expected %h", $time, what, got, exp);
			errors++;
			test_errs++;
		end
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (test_errs == 0) begin
			$display("Test %s passed", name);
		end else begin
			tests_failed++;
			$display("Test %s failed with %0d errors", name, test_errs);
		end
		test_errs = 0;
	endtask

	// One classic cycle, held until ACK or ERR, then STB drops
	task automatic bus_transfer(input logic we, input logic [31:0] adr, input logic [3:0] sel,
		input logic [31:0] wdat, output logic [31:0] rdat, output logic ack, output logic err);
		int waited;
		waited = 0;
		rdat = 32'h0;
		ack = 1'b0;
		err = 1'b0;
		@(negedge clk);
		m_cyc_i = 1'b1;
		m_stb_i = 1'b1;
		m_we_i = we;
		m_adr_i = adr;
		m_sel_i = sel;
		m_dat_i = wdat;
		do begin
			@(negedge clk);
			waited++;
		end while (!m_ack_o && !m_err_o && waited < XFER_LIMIT);
		if (m_ack_o || m_err_o) begin
			rdat = m_dat_o;
			ack = m_ack_o;
			err = m_err_o;
		end else begin
			$display("No ACK or ERR for the transfer to %h within %0d cycles", adr, XFER_LIMIT);
			errors++;
			test_errs++;
		end
		m_cyc_i = 1'b0;
		m_stb_i = 1'b0;
		m_we_i = 1'b0;
	endtask

	task automatic write_expect(input logic [31:0] adr, input logic [31:0] dat,
		input logic [3:0] sel, input string what);
		logic [31:0] rdat;
		logic        ack;
		logic        err;
		logic        exp_err;
		exp_err = expect_err(adr, 1'b1);
		bus_transfer(1'b1, adr, sel, dat, rdat, ack, err);
		check($sformatf("%s %h ack", what, adr), ack, !exp_err);
		check($sformatf("%s %h err", what, adr), err, exp_err);
		if (decode_addr(adr) == wb_pkg::TGT_ERR) begin
			check($sformatf("%s %h data", what, adr), rdat, 32'h0);
		end
		if (!exp_err) begin
			model_write(adr, dat, sel);
		end
	endtask

	task automatic read_expect(input logic [31:0] adr, input string what);
		logic [31:0] rdat;
		logic [31:0] exp;
		logic [31:0] mask;
		logic        ack;
		logic        err;
		logic        exp_err;
		exp_err = expect_err(adr, 1'b0);
		model_read(adr, gpio_i, exp, mask);
		bus_transfer(1'b0, adr, 4'hF, 32'h0, rdat, ack, err);
		check($sformatf("%s %h ack", what, adr), ack, !exp_err);
		check($sformatf("%s %h err", what, adr), err, exp_err);
		check($sformatf("%s %h data", what, adr), rdat & mask, exp & mask);
	endtask

	task automatic test_reset();
		@(negedge clk);
		check("m_ack_o after reset", m_ack_o, 0);
		check("m_err_o after reset", m_err_o, 0);
		check("selected target after reset", i_dut.i_ic.sel, wb_pkg::TGT_NONE);
		check("gpio_o after reset", gpio_o, 32'h0);
		check("irq_o after reset", irq_o, 0);
		end_test("reset_state");
	endtask

	task automatic test_sram();
		logic [31:0] adr;
		int          i;
		for (i = 0; i < N_SRAM; i++) begin
			adr = sram_addr();
			write_expect(adr, lcg_next(), rand_sel(), "sram write");
			read_expect(adr, "sram read");
		end
		end_test("sram_random");
	endtask

	task automatic test_regs();
		int i;
		read_expect(reg_addr(wb_pkg::REG_ID), "id read");
		// Full word first so every scratch lane is known
		write_expect(reg_addr(wb_pkg::REG_SCRATCH), lcg_next(), 4'hF, "scratch fill");
		for (i = 0; i < 8; i++) begin
			write_expect(reg_addr(wb_pkg::REG_SCRATCH), lcg_next(), rand_sel(), "scratch write");
			read_expect(reg_addr(wb_pkg::REG_SCRATCH), "scratch read");
		end
		for (i = 0; i < 4; i++) begin
			write_expect(reg_addr(wb_pkg::REG_GPIO_OUT), lcg_next(), rand_sel(), "gpio_out write");
			check("gpio_o pins", gpio_o, gpio_out_word);
			read_expect(reg_addr(wb_pkg::REG_GPIO_OUT), "gpio_out read");
		end
		for (i = 0; i < 4; i++) begin
			gpio_i = lcg_next();
			read_expect(reg_addr(wb_pkg::REG_GPIO_IN), "gpio_in read");
		end
		end_test("register_block");
	endtask

	task automatic test_readonly();
		write_expect(reg_addr(wb_pkg::REG_ID), lcg_next(), 4'hF, "id write");
		write_expect(reg_addr(wb_pkg::REG_GPIO_IN), lcg_next(), 4'hF, "gpio_in write");
		read_expect(reg_addr(wb_pkg::REG_ID), "id read after write");
		read_expect(reg_addr(wb_pkg::REG_GPIO_IN), "gpio_in read after write");
		read_expect(reg_addr(wb_pkg::REG_SCRATCH), "scratch unchanged");
		read_expect(reg_addr(wb_pkg::REG_GPIO_OUT), "gpio_out unchanged");
		check("gpio_o unchanged", gpio_o, gpio_out_word);
		end_test("read_only");
	endtask

	task automatic test_decode();
		logic [31:0] adr;
		int          i;
		for (i = 0; i < N_DEC; i++) begin
			adr = outside_addr();
			if (i % 2 == 1) begin
				write_expect(adr, lcg_next(), rand_sel(), "unmapped write");
			end else begin
				read_expect(adr, "unmapped read");
			end
		end
		// Bus must still work after the error responses
		adr = sram_addr();
		write_expect(adr, lcg_next(), 4'hF, "sram write after decode fail");
		read_expect(adr, "sram read after decode fail");
		end_test("decode_fail");
	endtask

	task automatic test_timer();
		logic [31:0] start;
		logic [31:0] rdat;
		logic        ack;
		logic        err;
		int          waited;
		// Small start value keeps the compare far from the reset compare
		start = lcg_next() & 32'h0000_FFFF;
		check("irq_o before timer setup", irq_o, 0);
		write_expect(tmr_addr(wb_pkg::TMR_COUNT), start, 4'hF, "timer count write");
		bus_transfer(1'b0, tmr_addr(wb_pkg::TMR_COUNT), 4'hF, 32'h0, rdat, ack, err);
		check("timer count readback", rdat, start);
		write_expect(tmr_addr(wb_pkg::TMR_CMP), start + 32'd50, 4'hF, "timer compare write");
		// Run plus interrupt enable
		write_expect(tmr_addr(wb_pkg::TMR_CTRL), 32'h3, 4'hF, "timer enable");
		waited = 0;
		while (!irq_o && waited < 200) begin
			@(negedge clk);
			waited++;
		end
		if (!irq_o) begin
			$display("irq_o did not rise within 200 cycles of enabling the timer");
			errors++;
			test_errs++;
		end
		bus_transfer(1'b0, tmr_addr(wb_pkg::TMR_STATUS), 4'hF, 32'h0, rdat, ack, err);
		check("timer status ack", ack, 1);
		check("timer status", rdat, 32'h1);
		write_expect(tmr_addr(wb_pkg::TMR_STATUS), 32'h1, 4'hF, "timer status clear");
		check("irq_o after status clear", irq_o, 0);
		write_expect(tmr_addr(wb_pkg::TMR_CTRL), 32'h0, 4'hF, "timer stop");
		end_test("timer_irq");
	endtask

	task automatic test_mixed();
		logic [31:0] r;
		logic [31:0] adr;
		int          base;
		int          i;
		@(negedge clk);
		base = resp_count;
		for (i = 0; i < N_MIX; i++) begin
			r = lcg_next();
			case (r % 3)
				0: adr = sram_addr();
				1: adr = reg_addr(r[5:4]);
				default: adr = outside_addr();
			endcase
			if (r[8]) begin
				write_expect(adr, lcg_next(), rand_sel(), "mixed write");
			end else begin
				read_expect(adr, "mixed read");
			end
		end
		@(negedge clk);
		// One response cycle per transfer, no more
		check("response cycles in mixed traffic", resp_count - base, N_MIX);
		check("gpio_o after mixed traffic", gpio_o, gpio_out_word);
		end_test("mixed_traffic");
	endtask

	initial begin
		clk = 1'b0;
		rstn = 1'b0;
		m_cyc_i = 1'b0;
		m_stb_i = 1'b0;
		m_we_i = 1'b0;
		m_adr_i = 32'h0;
		m_sel_i = 4'h0;
		m_dat_i = 32'h0;
		gpio_i = 32'h0;
		lcg_state = 45000;
		errors = 0;
		checks = 0;
		test_errs = 0;
		tests_run = 0;
		tests_failed = 0;
		resp_count = 0;
		model_reset();
		repeat (3) @(negedge clk);
		rstn = 1'b1;
		test_reset();
		test_sram();
		test_regs();
		test_readonly();
		test_decode();
		test_timer();
		test_mixed();
		$display("Tests run %0d, failed %0d, checks %0d, errors %0d",
			tests_run, tests_failed, checks, errors);
		if (errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

/* list.f */
+incdir+verif
common/wb_pkg.sv
wb_interconnect/wb_arbiter.sv
wb_interconnect/wb_interconnect.sv
logic/wb_sram.sv
logic/wb_gpio_regs.sv
logic/wb_timer.sv
logic/wb_subsys_top.sv
verif/tb_wb_subsys.sv
